// File: nkmm_pkg.sv
`default_nettype none

package nkmm_pkg;

    localparam int ACCUM_WIDTH  = 32;
    localparam int ADDR_WIDTH   = 16;
    localparam int PROG_WIDTH   = 32;
    localparam int IMM_WIDTH    = 16;
    localparam int REGSEL_WIDTH = 3;
    localparam int OP_WIDTH     = 3;
    localparam int NUM_GPR      = 7;

    typedef enum logic [OP_WIDTH-1:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_OR  = 3'd2,
        OP_AND = 3'd3,
        OP_XOR = 3'd4,
        OP_NOT = 3'd5,
        OP_SHI = 3'd6,
        OP_LD  = 3'd7
    } op_e;

    // Select 7 reads the PC, as a destination it discards the write
    typedef enum logic [REGSEL_WIDTH-1:0] {
        REG_R0 = 3'd0,
        REG_R1 = 3'd1,
        REG_R2 = 3'd2,
        REG_R3 = 3'd3,
        REG_R4 = 3'd4,
        REG_R5 = 3'd5,
        REG_R6 = 3'd6,
        REG_PC = 3'd7
    } reg_sel_e;

    // Shift amount field, bits 1:0 of operand B
    typedef enum logic [1:0] {
        SHI_1 = 2'd0,
        SHI_2 = 2'd1,
        SHI_4 = 2'd2,
        SHI_8 = 2'd3
    } shi_e;

    typedef struct packed {
        logic                 store;
        op_e                  op;
        reg_sel_e             dst;
        reg_sel_e             a_sel;
        reg_sel_e             b_sel;
        logic                 imm_en;
        logic [IMM_WIDTH-1:0] imm;
    } insn_t;

    typedef struct packed {
        logic                   valid;
        logic                   store;
        op_e                    op;
        reg_sel_e               dst;
        logic [ACCUM_WIDTH-1:0] a;
        logic [ACCUM_WIDTH-1:0] b;
    } ex_op_t;

    typedef struct packed {
        logic [ACCUM_WIDTH-1:0] value;
        logic                   wr;
    } ex_res_t;

    typedef struct packed {
        logic                   en;
        reg_sel_e               sel;
        logic [ACCUM_WIDTH-1:0] data;
    } reg_wr_t;

endpackage

`default_nettype wire

// File: nkmm_insn_decoder.sv
`default_nettype none

module nkmm_insn_decoder (
    input  logic [nkmm_pkg::PROG_WIDTH-1:0] insn_i,
    output nkmm_pkg::insn_t                 insn_o
);

    import nkmm_pkg::*;

    // Field layout
    //   30      store flag
    //   29:27   destination
    //   26:24   opcode
    //   23:21   A select
    //   20:18   B select
    //   17      immediate enable
    //   15:0    immediate
    always_comb begin
        insn_o.store  = insn_i[30];
        insn_o.dst    = reg_sel_e'(insn_i[29:27]);
        insn_o.op     = op_e'(insn_i[26:24]);
        insn_o.a_sel  = reg_sel_e'(insn_i[23:21]);
        insn_o.b_sel  = reg_sel_e'(insn_i[20:18]);
        insn_o.imm_en = insn_i[17];
        insn_o.imm    = insn_i[IMM_WIDTH-1:0];
    end

endmodule

`default_nettype wire

// File: nkmm_regfile.sv
`default_nettype none

module nkmm_regfile (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [nkmm_pkg::REGSEL_WIDTH-1:0] a_sel_i,
    input  logic [nkmm_pkg::REGSEL_WIDTH-1:0] b_sel_i,
    input  logic [nkmm_pkg::ADDR_WIDTH-1:0]   pc_i,
    input  nkmm_pkg::reg_wr_t                wr_i,
    output logic [nkmm_pkg::ACCUM_WIDTH-1:0]  a_o,
    output logic [nkmm_pkg::ACCUM_WIDTH-1:0]  b_o
);

    import nkmm_pkg::*;

    logic [ACCUM_WIDTH-1:0] regs_q [NUM_GPR];

    // r0-r6, the PC select never lands here
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.en && wr_i.sel != REG_PC) begin
            regs_q[wr_i.sel] <= wr_i.data;
        end
    end

    function automatic logic [ACCUM_WIDTH-1:0] read_reg(
        input logic [REGSEL_WIDTH-1:0] sel
    );
        logic [ACCUM_WIDTH-1:0] val;
        if (reg_sel_e'(sel) == REG_PC) begin
            // Fetch address of the reading instruction
            val = {{(ACCUM_WIDTH-ADDR_WIDTH){1'b0}}, pc_i};
        end else begin
            val = regs_q[sel];
        end
        return val;
    endfunction

    always_comb begin
        a_o = read_reg(a_sel_i);
        b_o = read_reg(b_sel_i);
    end

endmodule

`default_nettype wire

// File: nkmm_alu.sv
`default_nettype none

module nkmm_alu (
    input  nkmm_pkg::ex_op_t  op_i,
    output nkmm_pkg::ex_res_t res_o
);

    import nkmm_pkg::*;

    logic                   shl;
    shi_e                   shi;
    logic [ACCUM_WIDTH-1:0] shifted;
    logic [ACCUM_WIDTH-1:0] result;

    // Bit 2 of B picks the direction, bits 1:0 the distance
    always_comb begin
        shl = op_i.b[2];
        shi = shi_e'(op_i.b[1:0]);
        case (shi)
            SHI_1:   shifted = shl ? (op_i.a << 1) : (op_i.a >> 1);
            SHI_2:   shifted = shl ? (op_i.a << 2) : (op_i.a >> 2);
            SHI_4:   shifted = shl ? (op_i.a << 4) : (op_i.a >> 4);
            SHI_8:   shifted = shl ? (op_i.a << 8) : (op_i.a >> 8);
            default: shifted = op_i.a;
        endcase
    end

    always_comb begin
        case (op_i.op)
            OP_ADD:  result = op_i.a + op_i.b;
            OP_SUB:  result = op_i.a - op_i.b;
            OP_OR:   result = op_i.a | op_i.b;
            OP_AND:  result = op_i.a & op_i.b;
            OP_XOR:  result = op_i.a ^ op_i.b;
            OP_NOT:  result = ~op_i.b;
            OP_SHI:  result = shifted;
            // Loads are answered by the LSU
            default: result = '0;
        endcase
    end

    always_comb begin
        res_o.value = result;
        res_o.wr    = op_i.valid && !op_i.store && op_i.op != OP_LD;
    end

endmodule

`default_nettype wire

// File: nkmm_lsu.sv
`default_nettype none

module nkmm_lsu (
    input  nkmm_pkg::ex_op_t                 op_i,
    input  logic [nkmm_pkg::ACCUM_WIDTH-1:0] data_i,
    output logic [nkmm_pkg::ADDR_WIDTH-1:0]  rd_addr_o,
    output logic [nkmm_pkg::ADDR_WIDTH-1:0]  wr_addr_o,
    output logic [nkmm_pkg::ACCUM_WIDTH-1:0] data_o,
    output logic                             we_o,
    output nkmm_pkg::ex_res_t                res_o
);

    import nkmm_pkg::*;

    logic is_store;
    logic is_load;

    always_comb begin
        is_store = op_i.valid && op_i.store;
        is_load  = op_i.valid && !op_i.store && op_i.op == OP_LD;
    end

    // Both buses take their address from operand B
    always_comb begin
        rd_addr_o = op_i.b[ADDR_WIDTH-1:0];
        wr_addr_o = op_i.b[ADDR_WIDTH-1:0];
        data_o    = op_i.a;
        we_o      = is_store;
    end

    // Read data comes back in the same cycle
    always_comb begin
        res_o.value = data_i;
        res_o.wr    = is_load;
    end

endmodule

`default_nettype wire

// File: nkmm_writeback.sv
`default_nettype none

module nkmm_writeback (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid_i,
    input  logic [nkmm_pkg::REGSEL_WIDTH-1:0] dst_i,
    input  nkmm_pkg::ex_res_t                 alu_i,
    input  nkmm_pkg::ex_res_t                 lsu_i,
    output nkmm_pkg::reg_wr_t                 wr_o
);

    import nkmm_pkg::*;

    ex_res_t res;
    reg_wr_t wr_d;
    reg_wr_t wr_q;

    // At most one side flags its result
    always_comb begin
        res = alu_i.wr ? alu_i : lsu_i;
    end

    always_comb begin
        wr_d.sel  = reg_sel_e'(dst_i);
        wr_d.data = res.value;
        wr_d.en   = valid_i && res.wr && reg_sel_e'(dst_i) != REG_PC;
    end

    always_ff @(posedge clk) begin
        wr_q <= wr_d;
        if (rst) begin
            wr_q.en <= 1'b0;
        end
    end

    assign wr_o = wr_q;

endmodule

`default_nettype wire

// File: nkmm_cpu.sv
`default_nettype none

module nkmm_cpu (
    input  logic                             clk,
    input  logic                             rst,

    // Program bus
    input  logic [nkmm_pkg::PROG_WIDTH-1:0]  prog_data_i,
    output logic [nkmm_pkg::ADDR_WIDTH-1:0]  prog_addr_o,

    // Data bus
    input  logic [nkmm_pkg::ACCUM_WIDTH-1:0] data_i,
    output logic [nkmm_pkg::ACCUM_WIDTH-1:0] data_o,
    output logic [nkmm_pkg::ADDR_WIDTH-1:0]  rd_addr_o,
    output logic [nkmm_pkg::ADDR_WIDTH-1:0]  wr_addr_o,
    output logic                             we_o
);

    import nkmm_pkg::*;

    logic [ADDR_WIDTH-1:0]  pc_q;
    insn_t                  insn;
    logic [ACCUM_WIDTH-1:0] rd_a;
    logic [ACCUM_WIDTH-1:0] rd_b;
    ex_op_t                 ex_d;
    ex_op_t                 ex_q;
    ex_res_t                alu_res;
    ex_res_t                lsu_res;
    reg_wr_t                reg_wr;

    // Fetch, no branches so the PC only counts up
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_q + ADDR_WIDTH'(1);
        end
    end

    assign prog_addr_o = pc_q;

    nkmm_insn_decoder u_decoder (
        .insn_i (prog_data_i),
        .insn_o (insn)
    );

    nkmm_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .a_sel_i (insn.a_sel),
        .b_sel_i (insn.b_sel),
        .pc_i    (pc_q),
        .wr_i    (reg_wr),
        .a_o     (rd_a),
        .b_o     (rd_b)
    );

    // Decode stage
    always_comb begin
        ex_d.valid = 1'b1;
        ex_d.store = insn.store;
        ex_d.op    = insn.op;
        ex_d.dst   = insn.dst;
        ex_d.a     = rd_a;
        if (insn.imm_en) begin
            ex_d.b = {{(ACCUM_WIDTH-IMM_WIDTH){1'b0}}, insn.imm};
        end else begin
            ex_d.b = rd_b;
        end
    end

    always_ff @(posedge clk) begin
        ex_q <= ex_d;
        if (rst) begin
            ex_q.valid <= 1'b0;
        end
    end

    // Execute stage, ALU and LSU side by side
    nkmm_alu u_alu (
        .op_i  (ex_q),
        .res_o (alu_res)
    );

    nkmm_lsu u_lsu (
        .op_i      (ex_q),
        .data_i    (data_i),
        .rd_addr_o (rd_addr_o),
        .wr_addr_o (wr_addr_o),
        .data_o    (data_o),
        .we_o      (we_o),
        .res_o     (lsu_res)
    );

    nkmm_writeback u_writeback (
        .clk     (clk),
        .rst     (rst),
        .valid_i (ex_q.valid),
        .dst_i   (ex_q.dst),
        .alu_i   (alu_res),
        .lsu_i   (lsu_res),
        .wr_o    (reg_wr)
    );

endmodule

`default_nettype wire

// File: tb_nkmm_model.svh
`ifndef TB_NKMM_MODEL_SVH
`define TB_NKMM_MODEL_SVH

// Bits 31 and 16 are unused and encode as zero
function automatic logic [31:0] make_insn(
    input logic        store,
    input logic [2:0]  dst,
    input logic [2:0]  op,
    input logic [2:0]  a_sel,
    input logic [2:0]  b_sel,
    input logic        imm_en,
    input logic [15:0] imm
);
    return {1'b0, store, dst, op, a_sel, b_sel, imm_en, 1'b0, imm};
endfunction

function automatic logic [31:0] alu_imm(
    input logic [2:0]  op,
    input logic [2:0]  dst,
    input logic [2:0]  a_sel,
    input logic [15:0] imm
);
    return make_insn(1'b0, dst, op, a_sel, 3'd0, 1'b1, imm);
endfunction

function automatic logic [31:0] store_at(input logic [2:0] src, input logic [15:0] addr);
    return make_insn(1'b1, 3'd7, OP_OR, src, 3'd0, 1'b1, addr);
endfunction

function automatic logic [31:0] load_from(input logic [2:0] dst, input logic [15:0] addr);
    return make_insn(1'b0, dst, OP_LD, 3'd0, 3'd0, 1'b1, addr);
endfunction

// Initial data memory contents
function automatic logic [31:0] fill_word(input logic [7:0] addr);
    return {8'hc3, addr, ~addr, addr ^ 8'h5a};
endfunction

// Runs the program one instruction at a time and queues every store it makes
function automatic int run_model(input int len);
    logic [6:0][31:0] regs;
    logic [31:0]      mem [MEM_DEPTH];
    logic [31:0]      insn;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      res;
    op_e              op;
    store_t           st;
    int               count;
    regs  = '0;
    count = 0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
        mem[8'(i)] = fill_word(8'(i));
    end
    for (int pc = 0; pc < len; pc++) begin
        insn = prog_mem[8'(pc)];
        op   = op_e'(insn[26:24]);
        // Select 7 yields the address this instruction was fetched from
        a = (insn[23:21] == 3'd7) ? {16'h0000, 16'(pc)} : regs[insn[23:21]];
        b = (insn[20:18] == 3'd7) ? {16'h0000, 16'(pc)} : regs[insn[20:18]];
        if (insn[17]) begin
            b = {16'h0000, insn[15:0]};
        end
        if (insn[30]) begin
            st.pc   = 16'(pc);
            st.addr = b[15:0];
            st.data = a;
            expected.push_back(st);
            mem[b[7:0]] = a;
            count++;
        end else begin
            case (op)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_OR:   res = a | b;
                OP_AND:  res = a & b;
                OP_XOR:  res = a ^ b;
                OP_NOT:  res = ~b;
                OP_SHI:  res = b[2] ? (a << (1 << b[1:0])) : (a >> (1 << b[1:0]));
                default: res = mem[b[7:0]];
            endcase
            if (insn[29:27] != 3'd7) begin
                regs[insn[29:27]] = res;
            end
        end
    end
    return count;
endfunction

`endif

// File: tb_nkmm_cpu.sv
`default_nettype none

module tb_nkmm_cpu;

    import nkmm_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MEM_DEPTH  = 256;
    localparam int RAND_PROGS = 20;
    localparam int RAND_INSNS = 12;
    // OR into destination 7, no effect at all
    localparam logic [31:0] IDLE_INSN = 32'h3a00_0000;

    typedef struct packed {
        logic [15:0] pc;
        logic [15:0] addr;
        logic [31:0] data;
    } store_t;

    logic        clk;
    logic        rst;
    logic [31:0] prog_data;
    logic [15:0] prog_addr;
    logic [31:0] rd_data;
    logic [31:0] wr_data;
    logic [15:0] rd_addr;
    logic [15:0] wr_addr;
    logic        we;

    logic [31:0] prog_mem [MEM_DEPTH];
    logic [31:0] data_mem [MEM_DEPTH];
    int          prog_len;
    store_t      expected [$];
    logic [15:0] exp_pc;
    int          budget;
    int          cycles;
    integer      seed;

    nkmm_cpu dut0 (
        .clk         (clk),
        .rst         (rst),
        .prog_data_i (prog_data),
        .prog_addr_o (prog_addr),
        .data_i      (rd_data),
        .data_o      (wr_data),
        .rd_addr_o   (rd_addr),
        .wr_addr_o   (wr_addr),
        .we_o        (we)
    );

    assign prog_data = prog_mem[prog_addr[7:0]];
    assign rd_data   = data_mem[rd_addr[7:0]];

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // Reset restores the fill pattern
    initial begin : data_memory
        for (int i = 0; i < MEM_DEPTH; i++) begin
            data_mem[8'(i)] <= fill_word(8'(i));
        end
        forever begin
            @(posedge clk);
            if (rst) begin
                for (int i = 0; i < MEM_DEPTH; i++) begin
                    data_mem[8'(i)] <= fill_word(8'(i));
                end
            end else if (we) begin
                data_mem[wr_addr[7:0]] <= wr_data;
            end
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Fetch address and every store, checked once per cycle
    always @(posedge clk) begin : store_monitor
        store_t st;
        if (rst) begin
            exp_pc = '0;
        end else begin
            assert (prog_addr == exp_pc) else fail_now($sformatf(
                "[ERROR] %0t: prog_addr_o is %0d, expected %0d", $time, prog_addr, exp_pc));
            exp_pc = exp_pc + 16'd1;
            if (we) begin
                assert (expected.size() > 0) else fail_now(
                    "A store appeared that the program does not make");
                st = expected.pop_front();
                assert (prog_addr == st.pc + 16'd1 && wr_addr == st.addr && wr_data == st.data)
                    else fail_now($sformatf(
                        "[ERROR] %0t: store %h <- %h in cycle %0d, expected %h <- %h from pc %0d",
                        $time, wr_addr, wr_data, prog_addr, st.addr, st.data, st.pc));
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        @(posedge clk);
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        fail_now($sformatf("Timeout, the programs did not finish within %0d time units",
                           budget * CLK_PERIOD));
    end

    task automatic clear_program();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            prog_mem[8'(i)] = IDLE_INSN;
        end
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] insn);
        prog_mem[8'(prog_len)] = insn;
        prog_len++;
    endtask

    // Two idle slots keep every dependency three instructions apart
    task automatic emit_spaced(input logic [31:0] insn);
        emit(insn);
        emit(IDLE_INSN);
        emit(IDLE_INSN);
    endtask

    task automatic run_program();
        int stores;
        stores = run_model(prog_len);
        budget = budget + prog_len + 20;
        rst    = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // The last instruction has left execute once the PC is three past it
        while (int'(prog_addr) < prog_len + 3) begin
            @(negedge clk);
        end
        assert (expected.size() == 0) else fail_now($sformatf(
            "%0d expected stores never appeared", expected.size()));
        $display("Program of %0d words done, %0d stores", prog_len, stores);
    endtask

    initial begin : main
        rst    = 1'b1;
        seed   = 32'h56bb_17c8;
        budget = 0;

        // ALU operations, register and immediate forms
        clear_program();
        emit_spaced(alu_imm(OP_OR, 3'd1, 3'd0, 16'h1234));
        emit_spaced(alu_imm(OP_OR, 3'd2, 3'd0, 16'h80f0));
        for (int k = 0; k < 6; k++) begin
            emit_spaced(make_insn(1'b0, 3'd3, 3'(k), 3'd1, 3'd2, 1'b0, 16'h0000));
            emit_spaced(store_at(3'd3, 16'(16 + k)));
            emit_spaced(alu_imm(3'(k), 3'd4, 3'd2, 16'ha5c3));
            emit_spaced(store_at(3'd4, 16'(32 + k)));
        end
        run_program();

        // All eight shifts of 0x96c35a81
        clear_program();
        emit_spaced(alu_imm(OP_OR, 3'd1, 3'd0, 16'h96c3));
        emit_spaced(alu_imm(OP_SHI, 3'd1, 3'd1, 16'h0007));
        emit_spaced(alu_imm(OP_SHI, 3'd1, 3'd1, 16'h0007));
        emit_spaced(alu_imm(OP_OR, 3'd1, 3'd1, 16'h5a81));
        for (int k = 0; k < 8; k++) begin
            emit_spaced(alu_imm(OP_SHI, 3'd2, 3'd1, 16'(k)));
            emit_spaced(store_at(3'd2, 16'(48 + k)));
        end
        run_program();

        // Store, load back, store again
        clear_program();
        emit_spaced(alu_imm(OP_NOT, 3'd1, 3'd0, 16'h81ee));
        emit_spaced(store_at(3'd1, 16'h0040));
        emit_spaced(load_from(3'd2, 16'h0040));
        emit_spaced(store_at(3'd2, 16'h0041));
        emit_spaced(load_from(3'd3, 16'h00c7));
        emit_spaced(store_at(3'd3, 16'h0042));
        run_program();

        // PC as an operand, destination 7 writes nothing
        clear_program();
        for (int k = 1; k < 7; k++) begin
            emit_spaced(alu_imm(OP_XOR, 3'(k), 3'd0, 16'(k * 32'h1111)));
        end
        emit(store_at(3'd7, 16'h0050));
        emit(store_at(3'd7, 16'h0051));
        emit_spaced(alu_imm(OP_ADD, 3'd7, 3'd1, 16'h0101));
        emit_spaced(load_from(3'd7, 16'h0040));
        for (int k = 0; k < 7; k++) begin
            emit_spaced(store_at(3'(k), 16'(88 + k)));
        end
        run_program();

        for (int p = 0; p < RAND_PROGS; p++) begin
            clear_program();
            for (int k = 0; k < RAND_INSNS; k++) begin
                emit_spaced($random(seed));
            end
            run_program();
        end

        $display("** PASS **");
        $finish;
    end

    `include "tb_nkmm_model.svh"

endmodule

`default_nettype wire

// File: src.f
+incdir+.
nkmm_pkg.sv
nkmm_insn_decoder.sv
nkmm_regfile.sv
nkmm_alu.sv
nkmm_lsu.sv
nkmm_writeback.sv
nkmm_cpu.sv
tb_nkmm_cpu.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_nkmm_cpu -f src.f -o sim_nkmm \
    || { echo "Build failed"; exit 1; }
( ./obj_dir/sim_nkmm > sim.log 2>&1 || true ) \
    && grep -qxF '** PASS **' sim.log \
    && echo "Simulation passed" \
    || { cat sim.log; echo "Simulation failed"; exit 1; }
